// File: hdl/mcu_pkg.sv
// Shared widths, store-kind encoding and store configuration type
// EMUL derivation used by the configuration registers

package mcu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Vector register length in bits
  localparam int VLEN    = 8192;
  localparam int VL_W    = $clog2(VLEN);
  localparam int ADDR_W  = 32;
  // sew, lmul and data width codes
  localparam int FIELD_W = 3;

  ////////////////////////////////////////
  // Store encodings
  ////////////////////////////////////////

  // Concatenation of the unit, strided and indexed flags
  // Any pattern other than strided is drained as unit
  typedef enum logic [2:0] {
    STORE_STRIDED = 3'b010,
    STORE_UNIT    = 3'b100
  } store_kind_e;

  typedef struct packed {
    store_kind_e          kind;
    logic [FIELD_W-1:0]   data_sew;
    logic [FIELD_W-1:0]   data_lmul;
  } store_cfg_t;

  // EMUL as a signed exponent: lmul + eew - sew, wrapped to three bits
  // Codes 5, 6 and 7 stand for fractional groupings 1/8, 1/4 and 1/2
  function automatic logic [FIELD_W-1:0] emul_of(
    input logic [FIELD_W-1:0] data_width,
    input logic [FIELD_W-1:0] lmul,
    input logic [FIELD_W-1:0] sew
  );
    logic [FIELD_W-1:0] emul;
    emul = lmul + data_width - sew;
    return emul;
  endfunction

endpackage

// File: hdl/sbuff_read_if.sv
// Store data buffer read interface
// Read controller drives the strobes, the valid pipeline reports back

`timescale 1ns/1ps

interface sbuff_read_if;

  // A buffer read was issued this cycle
  logic rvalid;
  // Freeze the valid pipeline
  logic stall;
  // Buffer not ready, mask the write-stream valid
  logic invalidate;
  // Level that the write-start pulse is taken from
  logic wstart_level;
  // No reads in flight
  logic pipe_empty;
  // Gated write-stream valid
  logic tvalid;

  modport ctrl (
    output rvalid, stall, invalidate, wstart_level,
    input  pipe_empty, tvalid
  );

  modport pipe (
    input  rvalid, stall, invalidate, wstart_level,
    output pipe_empty, tvalid
  );

endinterface

// File: hdl/store_cfg_regs.sv
// Store configuration registers
// Kind from the access flags, data width and EMUL captured per store

`timescale 1ns/1ps

module store_cfg_regs
  import mcu_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               capture_i,
  input  logic [FIELD_W-1:0] sew_i,
  input  logic [FIELD_W-1:0] lmul_i,
  input  logic [FIELD_W-1:0] data_width_i,
  input  logic               unit_i,
  input  logic               strided_i,
  input  logic               idx_i,
  output store_cfg_t         cfg_o
);

  store_cfg_t cfg_reg;
  store_cfg_t cfg_next;

  ////////////////////////////////////////
  // Next configuration
  ////////////////////////////////////////

  always_comb begin
    // Raw flag pattern is kept, the read side decodes it
    cfg_next.kind = store_kind_e'({unit_i, strided_i, idx_i});
    // Unit and strided both store elements of the encoded data width
    cfg_next.data_sew  = data_width_i;
    cfg_next.data_lmul = emul_of(data_width_i, lmul_i, sew_i);
  end

  ////////////////////////////////////////
  // Capture
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_reg <= '0;
    end else if (capture_i) begin
      cfg_reg <= cfg_next;
    end
  end

  assign cfg_o = cfg_reg;

endmodule

// File: hdl/store_write_ctrl.sv
// Store write FSM
// Scheduler handshake, lane to buffer transfer and drain start

`timescale 1ns/1ps

module store_write_ctrl (
  input  logic clk,
  input  logic rstn,
  input  logic st_vld_i,
  input  logic vlane_dvalid_i,
  input  logic sdbuff_write_done_i,
  input  logic read_done_i,
  output logic st_rdy_o,
  output logic capture_o,
  output logic cfg_update_o,
  output logic cntr_rst_o,
  output logic baseaddr_set_o,
  output logic start_o,
  output logic vlane_rdy_o,
  output logic sbuff_wen_o
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_BUFFERED,
    W_WRITE,
    W_WAIT
  } wstate_e;

  wstate_e state_reg;
  wstate_e state_next;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_reg <= W_IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////

  always_comb begin
    state_next     = state_reg;
    st_rdy_o       = 1'b0;
    capture_o      = 1'b0;
    cfg_update_o   = 1'b0;
    cntr_rst_o     = 1'b0;
    baseaddr_set_o = 1'b0;
    start_o        = 1'b0;
    vlane_rdy_o    = 1'b0;
    sbuff_wen_o    = 1'b0;

    case (state_reg)
      W_IDLE: begin
        st_rdy_o = 1'b1;
        // Configuration is only present in the acceptance cycle
        if (st_vld_i) begin
          capture_o      = 1'b1;
          baseaddr_set_o = 1'b1;
          state_next     = W_BUFFERED;
        end
      end

      W_BUFFERED: begin
        // Buffer array picks up the registered configuration
        cfg_update_o = 1'b1;
        cntr_rst_o   = 1'b1;
        start_o      = 1'b1;
        state_next   = W_WRITE;
      end

      W_WRITE: begin
        vlane_rdy_o = 1'b1;
        sbuff_wen_o = vlane_dvalid_i;
        // Last element written
        if (vlane_dvalid_i && sdbuff_write_done_i) begin
          state_next = W_WAIT;
        end
      end

      W_WAIT: begin
        if (read_done_i) begin
          state_next = W_IDLE;
        end
      end

      default: begin
        state_next = W_IDLE;
      end
    endcase
  end

endmodule

// File: hdl/store_read_ctrl.sv
// Store read FSM
// Unit-stride burst drain and strided element-by-element drain

`timescale 1ns/1ps

module store_read_ctrl
  import mcu_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        start_i,
  input  store_kind_e kind_i,
  input  logic        sdbuff_read_rdy_i,
  input  logic        sdbuff_read_done_i,
  input  logic        wr_tready_i,
  input  logic        ctrl_wdone_i,
  sbuff_read_if.ctrl  rd,
  output logic        sdbuff_ren_o,
  output logic        baseaddr_update_o,
  output logic        done_o
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_UNIT,
    R_STRIDED,
    R_STRIDED_WAIT
  } rstate_e;

  rstate_e state_reg;
  rstate_e state_next;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_reg <= R_IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  ////////////////////////////////////////
  // Next state and buffer controls
  ////////////////////////////////////////

  always_comb begin
    state_next        = state_reg;
    rd.rvalid         = 1'b0;
    rd.stall          = 1'b0;
    rd.invalidate     = 1'b0;
    rd.wstart_level   = 1'b0;
    sdbuff_ren_o      = 1'b0;
    baseaddr_update_o = 1'b0;
    done_o            = 1'b0;

    case (state_reg)
      R_IDLE: begin
        if (start_i) begin
          if (kind_i == STORE_STRIDED) begin
            state_next = R_STRIDED;
          end else begin
            state_next = R_UNIT;
          end
        end
      end

      // Single burst for the whole vector
      R_UNIT: begin
        rd.wstart_level = 1'b1;
        if (sdbuff_read_rdy_i) begin
          rd.rvalid    = 1'b1;
          sdbuff_ren_o = 1'b1;
          if (ctrl_wdone_i) begin
            done_o     = 1'b1;
            state_next = R_IDLE;
          end
          // Nothing left to read
          if (sdbuff_read_done_i && wr_tready_i) begin
            rd.rvalid    = 1'b0;
            sdbuff_ren_o = 1'b0;
          end
          if (!wr_tready_i) begin
            rd.stall     = 1'b1;
            sdbuff_ren_o = 1'b0;
          end
        end else begin
          rd.stall      = 1'b1;
          rd.invalidate = 1'b1;
        end
      end

      // One element per transfer
      R_STRIDED: begin
        rd.wstart_level = 1'b1;
        if (sdbuff_read_rdy_i) begin
          rd.rvalid    = 1'b1;
          sdbuff_ren_o = 1'b1;
          if (rd.tvalid && wr_tready_i) begin
            state_next = R_STRIDED_WAIT;
            if (sdbuff_read_done_i) begin
              rd.rvalid    = 1'b0;
              sdbuff_ren_o = 1'b0;
            end
          end
          if (!wr_tready_i) begin
            rd.stall     = 1'b1;
            sdbuff_ren_o = 1'b0;
          end
        end else begin
          rd.stall      = 1'b1;
          rd.invalidate = 1'b1;
        end
      end

      // Element sent, hold the pipeline until the master is done
      R_STRIDED_WAIT: begin
        rd.stall = 1'b1;
        if (ctrl_wdone_i) begin
          baseaddr_update_o = 1'b1;
          state_next        = R_STRIDED;
          if (rd.pipe_empty) begin
            done_o     = 1'b1;
            state_next = R_IDLE;
          end
        end
      end

      default: begin
        state_next = R_IDLE;
      end
    endcase
  end

endmodule

// File: hdl/sdbuff_valid_pipe.sv
// Store buffer read-valid pipeline
// Write-stream valid, pipeline-empty flag and write-start pulse

`timescale 1ns/1ps

module sdbuff_valid_pipe (
  input  logic       clk,
  input  logic       rstn,
  input  logic       sdbuff_read_done_i,
  sbuff_read_if.pipe rd,
  output logic       wr_tvalid_o,
  output logic       ctrl_wstart_o
);

  // Read valid delayed to match the buffer read latency
  logic [2:0] rvalid_d;
  logic       tvalid_raw;
  logic       wstart_d;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid_d <= '0;
    end else if (!rd.stall) begin
      rvalid_d <= {rvalid_d[1:0], rd.rvalid};
    end
  end

  // Last element comes out one stage later
  assign tvalid_raw    = sdbuff_read_done_i ? rvalid_d[2] : rvalid_d[1];
  assign rd.tvalid     = rd.invalidate ? 1'b0 : tvalid_raw;
  assign rd.pipe_empty = (rvalid_d == 3'b000);
  assign wr_tvalid_o   = rd.tvalid;

  ////////////////////////////////////////
  // Write start edge
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wstart_d <= 1'b0;
    end else begin
      wstart_d <= rd.wstart_level;
    end
  end

  assign ctrl_wstart_o = rd.wstart_level && !wstart_d;

endmodule

// File: hdl/vec_store_cu.sv
// Vector store control unit top level
// Configuration registers, write and read FSMs, read-valid pipeline

`timescale 1ns/1ps

module vec_store_cu
  import mcu_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  // Scheduler configuration
  input  logic [FIELD_W-1:0] mcu_sew_i,
  input  logic [FIELD_W-1:0] mcu_lmul_i,
  input  logic [FIELD_W-1:0] mcu_data_width_i,
  input  logic               mcu_unit_ld_st_i,
  input  logic               mcu_strided_ld_st_i,
  input  logic               mcu_idx_ld_st_i,
  input  logic               mcu_st_vld_i,
  output logic               mcu_st_rdy_o,
  input  logic [ADDR_W-1:0]  mcu_base_addr_i,
  input  logic [ADDR_W-1:0]  mcu_stride_i,
  input  logic [31:0]        mcu_vl_i,
  // Buffer array configuration
  output logic [VL_W-1:0]    cfg_vl_o,
  output logic [FIELD_W-1:0] cfg_store_data_sew_o,
  output logic [FIELD_W-1:0] cfg_store_data_lmul_o,
  output logic [FIELD_W-1:0] store_type_o,
  // Buffer array and lane control
  output logic               store_cfg_update_o,
  output logic               store_cntr_rst_o,
  output logic               store_baseaddr_set_o,
  output logic               store_baseaddr_update_o,
  output logic [ADDR_W-1:0]  store_stride_o,
  output logic [ADDR_W-1:0]  store_baseaddr_o,
  output logic               sdbuff_read_stall_o,
  output logic               sdbuff_read_flush_o,
  output logic               sbuff_wen_o,
  output logic               sdbuff_ren_o,
  output logic               vlane_store_rdy_o,
  input  logic               sdbuff_write_done_i,
  input  logic               sdbuff_read_done_i,
  input  logic               sdbuff_read_rdy_i,
  input  logic               vlane_store_dvalid_i,
  // AXI write master control
  output logic               ctrl_wstart_o,
  input  logic               ctrl_wdone_i,
  output logic               wr_tvalid_o,
  input  logic               wr_tready_i
);

  logic       capture;
  logic       read_start;
  logic       read_done;
  store_cfg_t cfg;

  sbuff_read_if rd_if ();

  assign store_stride_o        = mcu_stride_i;
  assign store_baseaddr_o      = mcu_base_addr_i;
  assign cfg_vl_o              = mcu_vl_i[VL_W-1:0];
  assign store_type_o          = cfg.kind;
  assign cfg_store_data_sew_o  = cfg.data_sew;
  assign cfg_store_data_lmul_o = cfg.data_lmul;
  assign sdbuff_read_stall_o   = rd_if.stall;
  // No flush on the store data buffer
  assign sdbuff_read_flush_o   = 1'b0;

  store_cfg_regs u_cfg (
    .clk          (clk),
    .rstn         (rstn),
    .capture_i    (capture),
    .sew_i        (mcu_sew_i),
    .lmul_i       (mcu_lmul_i),
    .data_width_i (mcu_data_width_i),
    .unit_i       (mcu_unit_ld_st_i),
    .strided_i    (mcu_strided_ld_st_i),
    .idx_i        (mcu_idx_ld_st_i),
    .cfg_o        (cfg)
  );

  store_write_ctrl u_wr (
    .clk                 (clk),
    .rstn                (rstn),
    .st_vld_i            (mcu_st_vld_i),
    .vlane_dvalid_i      (vlane_store_dvalid_i),
    .sdbuff_write_done_i (sdbuff_write_done_i),
    .read_done_i         (read_done),
    .st_rdy_o            (mcu_st_rdy_o),
    .capture_o           (capture),
    .cfg_update_o        (store_cfg_update_o),
    .cntr_rst_o          (store_cntr_rst_o),
    .baseaddr_set_o      (store_baseaddr_set_o),
    .start_o             (read_start),
    .vlane_rdy_o         (vlane_store_rdy_o),
    .sbuff_wen_o         (sbuff_wen_o)
  );

  store_read_ctrl u_rd (
    .clk                (clk),
    .rstn               (rstn),
    .start_i            (read_start),
    .kind_i             (cfg.kind),
    .sdbuff_read_rdy_i  (sdbuff_read_rdy_i),
    .sdbuff_read_done_i (sdbuff_read_done_i),
    .wr_tready_i        (wr_tready_i),
    .ctrl_wdone_i       (ctrl_wdone_i),
    .rd                 (rd_if.ctrl),
    .sdbuff_ren_o       (sdbuff_ren_o),
    .baseaddr_update_o  (store_baseaddr_update_o),
    .done_o             (read_done)
  );

  sdbuff_valid_pipe u_pipe (
    .clk                (clk),
    .rstn               (rstn),
    .sdbuff_read_done_i (sdbuff_read_done_i),
    .rd                 (rd_if.pipe),
    .wr_tvalid_o        (wr_tvalid_o),
    .ctrl_wstart_o      (ctrl_wstart_o)
  );

endmodule

// File: verification/store_cu_checker.sv
// Port-level checker for the vector store control unit
// Models capture, lane write and drain strobes, counts mismatches

`timescale 1ns/1ps

module store_cu_checker
  import mcu_pkg::*;
(
  input logic               clk,
  input logic               rstn,
  input logic [FIELD_W-1:0] mcu_sew_i, mcu_lmul_i, mcu_data_width_i,
  input logic               mcu_unit_ld_st_i, mcu_strided_ld_st_i, mcu_idx_ld_st_i,
  input logic               mcu_st_vld_i, mcu_st_rdy_o,
  input logic [ADDR_W-1:0]  mcu_base_addr_i, mcu_stride_i,
  input logic [ADDR_W-1:0]  store_stride_o, store_baseaddr_o,
  input logic [31:0]        mcu_vl_i,
  input logic [VL_W-1:0]    cfg_vl_o,
  input logic [FIELD_W-1:0] cfg_store_data_sew_o, cfg_store_data_lmul_o, store_type_o,
  input logic               store_cfg_update_o, store_cntr_rst_o,
  input logic               store_baseaddr_set_o, store_baseaddr_update_o,
  input logic               sdbuff_read_stall_o, sdbuff_read_flush_o,
  input logic               sbuff_wen_o, sdbuff_ren_o, vlane_store_rdy_o,
  input logic               sdbuff_write_done_i, sdbuff_read_done_i,
  input logic               sdbuff_read_rdy_i, vlane_store_dvalid_i,
  input logic               ctrl_wstart_o, ctrl_wdone_i, wr_tvalid_o, wr_tready_i
);

  // Read side as seen from the ports
  typedef enum logic [1:0] {
    M_IDLE,
    M_UNIT,
    M_SEND,
    M_WAIT
  } mstate_e;

  int         errors = 0;
  int         age;
  logic       after_reset;
  logic       draining;
  logic       prev_drain;
  logic       accept;
  logic       read_end;
  logic       exp_rdy;
  logic       exp_vrdy;
  logic       exp_tvalid;
  logic [2:0] exp_pipe;
  logic [2:0] exp_type;
  logic [2:0] exp_sew;
  logic [2:0] exp_lmul;
  mstate_e    mstate;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  // lmul codes 5..7 are negative exponents
  function automatic logic [2:0] expected_emul(input logic [2:0] dw, lmul, sew);
    int e;
    e = (lmul > 3'd3) ? int'(lmul) - 8 : int'(lmul);
    e = e + int'(dw) - int'(sew);
    return e[2:0];
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      after_reset = 1'b1;
      age         = 100;
      mstate      = M_IDLE;
      prev_drain  = 1'b0;
      exp_rdy     = 1'b1;
      exp_vrdy    = 1'b0;
      exp_pipe    = '0;
      exp_type    = '0;
      exp_sew     = '0;
      exp_lmul    = '0;
    end else begin
      if (after_reset) begin
        compare("sdbuff_ren_o", 0, sdbuff_ren_o);
        compare("sdbuff_read_stall_o", 0, sdbuff_read_stall_o);
        after_reset = 1'b0;
      end
      draining = (mstate == M_UNIT) || (mstate == M_SEND);
      accept   = exp_rdy && mcu_st_vld_i;
      // Stage 2 carries the last element, stage 1 all others
      exp_tvalid = sdbuff_read_done_i ? exp_pipe[2] : exp_pipe[1];
      if (draining && !sdbuff_read_rdy_i) begin
        exp_tvalid = 1'b0;
      end

      ////////////////////////////////////////
      // Pass-through and configuration
      ////////////////////////////////////////
      compare("mcu_st_rdy_o", exp_rdy, mcu_st_rdy_o);
      compare("store_baseaddr_o", mcu_base_addr_i, store_baseaddr_o);
      compare("store_stride_o", mcu_stride_i, store_stride_o);
      compare("cfg_vl_o", mcu_vl_i[VL_W-1:0], cfg_vl_o);
      compare("store_baseaddr_set_o", accept, store_baseaddr_set_o);
      compare("store_cfg_update_o", age == 1, store_cfg_update_o);
      compare("store_cntr_rst_o", age == 1, store_cntr_rst_o);
      compare("store_type_o", exp_type, store_type_o);
      compare("cfg_store_data_sew_o", exp_sew, cfg_store_data_sew_o);
      compare("cfg_store_data_lmul_o", exp_lmul, cfg_store_data_lmul_o);

      // Lane write and drain gating
      compare("vlane_store_rdy_o", exp_vrdy, vlane_store_rdy_o);
      compare("sbuff_wen_o", exp_vrdy && vlane_store_dvalid_i, sbuff_wen_o);
      compare("wr_tvalid_o", exp_tvalid, wr_tvalid_o);
      if (!wr_tready_i) begin
        compare("sdbuff_ren_o", 0, sdbuff_ren_o);
      end
      if (draining && !wr_tready_i) begin
        compare("sdbuff_read_stall_o", 1, sdbuff_read_stall_o);
      end
      compare("ctrl_wstart_o", draining && !prev_drain, ctrl_wstart_o);
      compare("store_baseaddr_update_o", (mstate == M_WAIT) && ctrl_wdone_i,
              store_baseaddr_update_o);
      compare("sdbuff_read_flush_o", 0, sdbuff_read_flush_o);

      ////////////////////////////////////////
      // Model update
      ////////////////////////////////////////
      if (exp_vrdy && vlane_store_dvalid_i && sdbuff_write_done_i) begin
        exp_vrdy = 1'b0;
      end
      // Unit ends on the master's done, strided also needs an empty pipeline
      read_end = ctrl_wdone_i &&
                 (((mstate == M_UNIT) && sdbuff_read_rdy_i) ||
                  ((mstate == M_WAIT) && (exp_pipe == 3'b000)));
      case (mstate)
        M_SEND: if (exp_tvalid && wr_tready_i) mstate = M_WAIT;
        M_WAIT: if (ctrl_wdone_i) mstate = M_SEND;
        default: ;
      endcase
      if (read_end) begin
        mstate  = M_IDLE;
        exp_rdy = 1'b1;
      end
      if (age == 1) begin
        exp_vrdy = 1'b1;
        mstate   = (exp_type == STORE_STRIDED) ? M_SEND : M_UNIT;
      end
      prev_drain = draining;
      // Reads enter the pipeline only while it is not frozen
      if (!sdbuff_read_stall_o) begin
        exp_pipe = {exp_pipe[1:0], sdbuff_ren_o};
      end
      if (accept) begin
        exp_rdy  = 1'b0;
        exp_type = {mcu_unit_ld_st_i, mcu_strided_ld_st_i, mcu_idx_ld_st_i};
        exp_sew  = mcu_data_width_i;
        exp_lmul = expected_emul(mcu_data_width_i, mcu_lmul_i, mcu_sew_i);
        age      = 1;
      end else if (age < 100) begin
        age++;
      end
    end
  end

endmodule

// File: verification/tb_vec_store_cu.sv
// Testbench for the vector store control unit
// Clock, reset, random store stimulus, buffer and AXI responders

`timescale 1ns/1ps

module tb_vec_store_cu
  import mcu_pkg::*;
();

  logic               clk;
  logic               rstn;
  logic [FIELD_W-1:0] mcu_sew_i, mcu_lmul_i, mcu_data_width_i;
  logic               mcu_unit_ld_st_i, mcu_strided_ld_st_i, mcu_idx_ld_st_i;
  logic               mcu_st_vld_i, mcu_st_rdy_o;
  logic [ADDR_W-1:0]  mcu_base_addr_i, mcu_stride_i, store_stride_o, store_baseaddr_o;
  logic [31:0]        mcu_vl_i;
  logic [VL_W-1:0]    cfg_vl_o;
  logic [FIELD_W-1:0] cfg_store_data_sew_o, cfg_store_data_lmul_o, store_type_o;
  logic               store_cfg_update_o, store_cntr_rst_o;
  logic               store_baseaddr_set_o, store_baseaddr_update_o;
  logic               sdbuff_read_stall_o, sdbuff_read_flush_o;
  logic               sbuff_wen_o, sdbuff_ren_o, vlane_store_rdy_o;
  logic               sdbuff_write_done_i, sdbuff_read_done_i;
  logic               sdbuff_read_rdy_i, vlane_store_dvalid_i;
  logic               ctrl_wstart_o, ctrl_wdone_i, wr_tvalid_o, wr_tready_i;

  integer seed;
  int     timeouts;

  vec_store_cu UUT (.*);
  store_cu_checker chk (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  ////////////////////////////////////////
  // One store: handshake, lane write, drain
  ////////////////////////////////////////

  task automatic run_store();
    int         cnt;
    int         r;
    int         wr_cnt;
    int         wr_len;
    int         hs_cnt;
    int         rd_len;
    logic       strided;
    logic [2:0] flags;
    cnt = 0;
    @(posedge clk);
    while (!mcu_st_rdy_o) begin
      cnt++;
      if (cnt > 50) begin
        $display("Timeout: the store interface never became ready");
        timeouts++;
        return;
      end
      @(posedge clk);
    end
    flags   = rand_below(2) ? 3'b010 : 3'b100;
    strided = (flags == STORE_STRIDED);
    r       = rand_below(7);
    mcu_sew_i        <= 3'(rand_below(3));
    mcu_lmul_i       <= 3'((r > 3) ? r + 1 : r);
    mcu_data_width_i <= 3'(rand_below(3));
    {mcu_unit_ld_st_i, mcu_strided_ld_st_i, mcu_idx_ld_st_i} <= flags;
    mcu_base_addr_i  <= $random(seed);
    mcu_stride_i     <= $random(seed);
    mcu_vl_i         <= $random(seed);
    mcu_st_vld_i     <= 1'b1;
    wr_len = 1 + rand_below(6);
    rd_len = rand_below(4);
    wr_cnt = 0;
    hs_cnt = 0;
    @(posedge clk);
    // Scheduler holds the configuration for the acceptance cycle only
    mcu_st_vld_i     <= 1'b0;
    mcu_sew_i        <= 3'(rand_below(8));
    mcu_lmul_i       <= 3'(rand_below(8));
    mcu_data_width_i <= 3'(rand_below(8));
    cnt = 0;
    while (!(sbuff_wen_o && sdbuff_write_done_i)) begin
      if (sbuff_wen_o) begin
        wr_cnt++;
      end
      vlane_store_dvalid_i <= rand_below(2) != 0;
      sdbuff_write_done_i  <= (wr_cnt == wr_len - 1);
      sdbuff_read_rdy_i    <= rand_below(4) != 0;
      wr_tready_i          <= rand_below(4) != 0;
      cnt++;
      if (cnt > 200) begin
        $display("Timeout: the lane write never finished");
        timeouts++;
        return;
      end
      @(posedge clk);
    end
    vlane_store_dvalid_i <= 1'b0;
    sdbuff_write_done_i  <= 1'b0;
    // AXI master and buffer responder for the drain
    cnt = 0;
    while (!mcu_st_rdy_o) begin
      if (wr_tvalid_o && wr_tready_i) begin
        hs_cnt++;
      end
      sdbuff_read_rdy_i  <= rand_below(4) != 0;
      wr_tready_i        <= rand_below(4) != 0;
      sdbuff_read_done_i <= (hs_cnt >= rd_len);
      ctrl_wdone_i       <= (strided || hs_cnt >= rd_len) && rand_below(2) != 0;
      cnt++;
      if (cnt > 400) begin
        $display("Timeout: the store drain never returned ready");
        timeouts++;
        return;
      end
      @(posedge clk);
    end
    ctrl_wdone_i       <= 1'b0;
    sdbuff_read_done_i <= 1'b0;
  endtask

  initial begin
    int stores;
    seed                 = 32'h338f;
    timeouts             = 0;
    rstn                 = 1'b0;
    mcu_sew_i            = '0;
    mcu_lmul_i           = '0;
    mcu_data_width_i     = '0;
    mcu_unit_ld_st_i     = 1'b0;
    mcu_strided_ld_st_i  = 1'b0;
    mcu_idx_ld_st_i      = 1'b0;
    mcu_st_vld_i         = 1'b0;
    mcu_base_addr_i      = '0;
    mcu_stride_i         = '0;
    mcu_vl_i             = '0;
    sdbuff_write_done_i  = 1'b0;
    sdbuff_read_done_i   = 1'b0;
    sdbuff_read_rdy_i    = 1'b0;
    vlane_store_dvalid_i = 1'b0;
    ctrl_wdone_i         = 1'b0;
    wr_tready_i          = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    stores = 0;
    while (stores < 40 && timeouts == 0) begin
      run_store();
      stores++;
    end
    $display("Error counts: %0d check, %0d timeout, over %0d stores",
             chk.errors, timeouts, stores);
    if (chk.errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tb.f
hdl/mcu_pkg.sv
hdl/sbuff_read_if.sv
hdl/store_cfg_regs.sv
hdl/store_write_ctrl.sv
hdl/store_read_ctrl.sv
hdl/sdbuff_valid_pipe.sv
hdl/vec_store_cu.sv
verification/store_cu_checker.sv
verification/tb_vec_store_cu.sv
